// File: sim/rv_core_cases.txt
// first word is the number of steps, then one step per line:
// inst pc gpr_w_en rd rd_data mem_w_en mem_w_addr mem_w_data halted
00000013
00500093 80000000 1 01 00000005 0 00000000 00000000 0
ffd00113 80000004 1 02 fffffffd 0 00000000 00000000 0
002081b3 80000008 1 03 00000002 0 00000000 00000000 0
06408013 8000000c 1 00 00000069 0 00000000 00000000 0
00000233 80000010 1 04 00000000 0 00000000 00000000 0
00001297 80000014 1 05 80001014 0 00000000 00000000 0
0100036f 80000018 1 06 8000001c 0 00000000 00000000 0
821283e7 80000028 1 07 8000002c 0 00000000 00000000 0
00318463 80000834 0 00 00000000 0 00000000 00000000 0
00208863 8000083c 0 00 00000000 0 00000000 00000000 0
0022a623 80000840 0 00 00000000 1 80001020 fffffffd 0
fe63ac23 80000844 0 00 00000000 1 80000024 8000001c 0
ffffffff 80000848 0 00 00000000 0 00000000 00000000 0
00638433 80000848 1 08 00000048 0 00000000 00000000 0
00100073 8000084c 0 00 00000000 0 00000000 00000000 0
00100493 8000084c 0 00 00000000 0 00000000 00000000 1
00102023 8000084c 0 00 00000000 0 00000000 00000000 1
008000ef 8000084c 0 00 00000000 0 00000000 00000000 1
00108533 8000084c 0 00 00000000 0 00000000 00000000 1

// File: tb.f
+incdir+common
common/rv_isa_pkg.sv
common/rv_alu_pkg.sv
core/idu.sv
core/alu.sv
core/gpr_file.sv
core/exu.sv
hw/pc_reg.sv
hw/rv_core.sv
sim/tb_rv_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f tb.f --top-module tb_rv_core -o Vtb_rv_core

./obj_dir/Vtb_rv_core | tee sim.log

if grep -q "Test completed successfully" sim.log
then
    echo "simulation passed"
else
    echo "simulation did not pass"
    exit 1
fi

// File: sim/tb_rv_core.sv
`timescale 1ns/100ps
`include "rv_macros.svh"

module tb_rv_core;

    localparam int FIELDS    = 9;
    localparam int MAX_CASES = 64;

    logic                   clk;
    logic                   rst_n;
    logic [`XLEN-1:0]       inst;
    logic [`XLEN-1:0]       pc;
    logic                   halted;
    logic                   gpr_w_en;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       rd_data;
    logic                   mem_w_en;
    logic [`XLEN-1:0]       mem_w_addr;
    logic [`XLEN-1:0]       mem_w_data;

    logic [`XLEN-1:0] case_words [0:FIELDS*MAX_CASES]; // word 0 is the step count
    int               num_cases;
    int               cycle_count;
    int               cycle_limit;

    rv_core rv_core_inst
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst       (inst),
        .pc         (pc),
        .halted     (halted),
        .gpr_w_en   (gpr_w_en),
        .rd         (rd),
        .rd_data    (rd_data),
        .mem_w_en   (mem_w_en),
        .mem_w_addr (mem_w_addr),
        .mem_w_data (mem_w_data)
    );

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit)
        begin
            $display("timeout: the run went past %0d cycles", cycle_limit);
            abort_run();
        end
    end

    task automatic check_pc(input logic [`XLEN-1:0] exp_pc);
        if (pc !== exp_pc)
        begin
            $display("[ERROR] pc: expected %h, got %h", exp_pc, pc);
            abort_run();
        end
    endtask

    task automatic check_gpr_write(input logic                   exp_en,
                                   input logic [`REG_ADDR_W-1:0] exp_rd,
                                   input logic [`XLEN-1:0]       exp_data);
        if (gpr_w_en !== exp_en)
        begin
            $display("[ERROR] gpr_w_en: expected %h, got %h", exp_en, gpr_w_en);
            abort_run();
        end
        else if (exp_en && rd !== exp_rd)
        begin
            $display("[ERROR] rd: expected %h, got %h", exp_rd, rd);
            abort_run();
        end
        else if (exp_en && rd_data !== exp_data)
        begin
            $display("[ERROR] rd_data: expected %h, got %h", exp_data, rd_data);
            abort_run();
        end
    endtask

    task automatic check_store(input logic             exp_en,
                               input logic [`XLEN-1:0] exp_addr,
                               input logic [`XLEN-1:0] exp_data);
        if (mem_w_en !== exp_en)
        begin
            $display("[ERROR] mem_w_en: expected %h, got %h", exp_en, mem_w_en);
            abort_run();
        end
        else if (exp_en && mem_w_addr !== exp_addr)
        begin
            $display("[ERROR] mem_w_addr: expected %h, got %h", exp_addr, mem_w_addr);
            abort_run();
        end
        else if (exp_en && mem_w_data !== exp_data)
        begin
            $display("[ERROR] mem_w_data: expected %h, got %h", exp_data, mem_w_data);
            abort_run();
        end
    endtask

    task automatic check_halt(input logic exp_halted);
        if (halted !== exp_halted)
        begin
            $display("[ERROR] halted: expected %h, got %h", exp_halted, halted);
            abort_run();
        end
    endtask

    initial
    begin
        int base;
        clk         = 1'b0;
        rst_n       = 1'b0;
        inst        = '0;
        cycle_count = 0;
        cycle_limit = 0;
        $readmemh("sim/rv_core_cases.txt", case_words);
        num_cases = case_words[0];
        if (num_cases < 1 || num_cases > MAX_CASES)
        begin
            $display("the cases file gave no usable step count");
            abort_run();
        end
        cycle_limit = 2 * num_cases + 20;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_pc(`BASE_ADDR);
        check_halt(1'b0);
        for (int i = 0; i < num_cases; i++)
        begin
            base = 1 + i * FIELDS;
            @(negedge clk);
            inst = case_words[base];
            #1; // combinational outputs settle well before the next rising edge
            check_pc(case_words[base+1]);
            check_gpr_write(case_words[base+2][0], case_words[base+3][`REG_ADDR_W-1:0],
                            case_words[base+4]);
            check_store(case_words[base+5][0], case_words[base+6], case_words[base+7]);
            check_halt(case_words[base+8][0]);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: hw/rv_core.sv
`timescale 1ns/100ps
`include "rv_macros.svh"

module rv_core
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`XLEN-1:0]       inst,
    output logic [`XLEN-1:0]       pc,
    output logic                   halted,
    output logic                   gpr_w_en,
    output logic [`REG_ADDR_W-1:0] rd,
    output logic [`XLEN-1:0]       rd_data,
    output logic                   mem_w_en,
    output logic [`XLEN-1:0]       mem_w_addr,
    output logic [`XLEN-1:0]       mem_w_data
);

    rv_isa_pkg::inst_e      inst_id;
    rv_isa_pkg::fmt_e       fmt;
    rv_alu_pkg::alu_op_e    alu_op;
    logic [`XLEN-1:0]       imm;
    logic [`XLEN-1:0]       src1;
    logic [`XLEN-1:0]       src2;
    logic [`XLEN-1:0]       alu_a;
    logic [`XLEN-1:0]       alu_b;
    logic [`XLEN-1:0]       alu_result;
    logic [`XLEN-1:0]       next_pc;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic                   pc_w_en;

    idu idu_inst
    (
        .inst    (inst),
        .inst_id (inst_id),
        .fmt     (fmt),
        .imm     (imm),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd)
    );

    gpr_file gpr_file_inst
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .rd_data  (rd_data),
        .gpr_w_en (gpr_w_en),
        .src1     (src1),
        .src2     (src2)
    );

    exu exu_inst
    (
        .inst_id    (inst_id),
        .fmt        (fmt),
        .imm        (imm),
        .pc         (pc),
        .src1       (src1),
        .src2       (src2),
        .alu_result (alu_result),
        .halted     (halted),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_op     (alu_op),
        .next_pc    (next_pc),
        .pc_w_en    (pc_w_en),
        .rd_data    (rd_data),
        .gpr_w_en   (gpr_w_en),
        .mem_w_en   (mem_w_en),
        .mem_w_addr (mem_w_addr),
        .mem_w_data (mem_w_data)
    );

    alu alu_inst
    (
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_op     (alu_op),
        .alu_result (alu_result)
    );

    pc_reg pc_reg_inst
    (
        .clk     (clk),
        .rst_n   (rst_n),
        .next_pc (next_pc),
        .pc_w_en (pc_w_en),
        .inst_id (inst_id),
        .pc      (pc),
        .halted  (halted)
    );

endmodule

// File: hw/pc_reg.sv
`timescale 1ns/100ps
`include "rv_macros.svh"

module pc_reg
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [`XLEN-1:0]    next_pc,
    input  logic                pc_w_en,
    input  rv_isa_pkg::inst_e   inst_id,
    output logic [`XLEN-1:0]    pc,
    output logic                halted
);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            pc     <= `BASE_ADDR;
            halted <= 1'b0;
        end
        else
        begin
            if (pc_w_en && !halted)
                pc <= next_pc;
            if (inst_id == rv_isa_pkg::INST_EBREAK)
                halted <= 1'b1; // sticky until the next reset
        end
    end

    // exu masks the pc write enable once the core has halted
    pc_frozen_when_halted: assert property (
        @(posedge clk) disable iff (!rst_n)
        halted |-> !pc_w_en
    ) else $error("pc_reg: pc write requested while halted");

endmodule

// File: core/exu.sv
`timescale 1ns/100ps
`include "rv_macros.svh"

module exu
(
    input  rv_isa_pkg::inst_e    inst_id,
    input  rv_isa_pkg::fmt_e     fmt,
    input  logic [`XLEN-1:0]     imm,
    input  logic [`XLEN-1:0]     pc,
    input  logic [`XLEN-1:0]     src1,
    input  logic [`XLEN-1:0]     src2,
    input  logic [`XLEN-1:0]     alu_result,
    input  logic                 halted,
    output logic [`XLEN-1:0]     alu_a,
    output logic [`XLEN-1:0]     alu_b,
    output rv_alu_pkg::alu_op_e  alu_op,
    output logic [`XLEN-1:0]     next_pc,
    output logic                 pc_w_en,
    output logic [`XLEN-1:0]     rd_data,
    output logic                 gpr_w_en,
    output logic                 mem_w_en,
    output logic [`XLEN-1:0]     mem_w_addr,
    output logic [`XLEN-1:0]     mem_w_data
);

    logic [`XLEN-1:0] jump_base;
    logic [`XLEN-1:0] jump_offset;
    logic [`XLEN-1:0] jump_sum;
    logic             is_jalr;
    logic             is_ebreak;
    logic             is_store;
    logic             writes_rd;

    assign is_jalr   = inst_id == rv_isa_pkg::INST_JALR;
    assign is_ebreak = inst_id == rv_isa_pkg::INST_EBREAK;
    assign is_store  = fmt == rv_isa_pkg::FMT_S;

    always_comb
    begin
        alu_a  = '0;
        alu_b  = '0;
        alu_op = rv_alu_pkg::ALU_NONE;
        case (inst_id)
            rv_isa_pkg::INST_AUIPC:
            begin
                alu_a  = pc;
                alu_b  = imm;
                alu_op = rv_alu_pkg::ALU_ADD;
            end
            rv_isa_pkg::INST_JAL, rv_isa_pkg::INST_JALR:
            begin
                alu_a  = pc; // link address
                alu_b  = `XLEN'd4;
                alu_op = rv_alu_pkg::ALU_ADD;
            end
            rv_isa_pkg::INST_BEQ:
            begin
                alu_a  = src1;
                alu_b  = src2;
                alu_op = rv_alu_pkg::ALU_XOR;
            end
            rv_isa_pkg::INST_SW, rv_isa_pkg::INST_ADDI:
            begin
                alu_a  = src1;
                alu_b  = imm;
                alu_op = rv_alu_pkg::ALU_ADD;
            end
            rv_isa_pkg::INST_ADD:
            begin
                alu_a  = src1;
                alu_b  = src2;
                alu_op = rv_alu_pkg::ALU_ADD;
            end
            default: ;
        endcase
    end

    // kept apart from the operand mux since the beq decision reads alu_result
    always_comb
    begin
        jump_base   = is_jalr ? src1 : pc;
        jump_offset = `XLEN'd4;
        if (is_jalr || inst_id == rv_isa_pkg::INST_JAL)
            jump_offset = imm;
        else if (inst_id == rv_isa_pkg::INST_BEQ && alu_result == '0)
            jump_offset = imm; // operands equal, branch taken
    end

    assign jump_sum = jump_base + jump_offset;
    assign next_pc  = {jump_sum[`XLEN-1:1], jump_sum[0] & ~is_jalr};

    assign writes_rd = !is_ebreak && (fmt == rv_isa_pkg::FMT_R || fmt == rv_isa_pkg::FMT_I ||
                                      fmt == rv_isa_pkg::FMT_U || fmt == rv_isa_pkg::FMT_J);

    assign pc_w_en    = fmt != rv_isa_pkg::FMT_NONE && !is_ebreak && !halted;
    assign gpr_w_en   = writes_rd && !halted;
    assign rd_data    = writes_rd ? alu_result : '0;
    assign mem_w_en   = is_store && !halted;
    assign mem_w_addr = is_store ? alu_result : '0;
    assign mem_w_data = is_store ? src2 : '0;

    always_comb
    begin
        assert (!(mem_w_en && gpr_w_en))
            else $error("exu: store and register write in the same cycle");
        assert (!pc_w_en || next_pc[1:0] == 2'b00)
            else $error("exu: misaligned next pc %h", next_pc);
    end

endmodule

// File: core/gpr_file.sv
`timescale 1ns/100ps
`include "rv_macros.svh"

module gpr_file
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`REG_ADDR_W-1:0] rs1,
    input  logic [`REG_ADDR_W-1:0] rs2,
    input  logic [`REG_ADDR_W-1:0] rd,
    input  logic [`XLEN-1:0]       rd_data,
    input  logic                   gpr_w_en,
    output logic [`XLEN-1:0]       src1,
    output logic [`XLEN-1:0]       src2
);

    // x0 has no storage
    logic [`XLEN-1:0] regs [1:(1 << `REG_ADDR_W)-1];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 1; i < (1 << `REG_ADDR_W); i++)
                regs[i] <= '0;
        end
        else if (gpr_w_en && rd != '0)
        begin
            regs[rd] <= rd_data;
        end
    end

    assign src1 = (rs1 == '0) ? '0 : regs[rs1];
    assign src2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: core/alu.sv
`timescale 1ns/100ps
`include "rv_macros.svh"

module alu
(
    input  logic [`XLEN-1:0]     alu_a,
    input  logic [`XLEN-1:0]     alu_b,
    input  rv_alu_pkg::alu_op_e  alu_op,
    output logic [`XLEN-1:0]     alu_result
);

    always_comb
    begin
        case (alu_op)
            rv_alu_pkg::ALU_ADD: alu_result = alu_a + alu_b; // carry out is dropped
            rv_alu_pkg::ALU_XOR: alu_result = alu_a ^ alu_b;
            default:             alu_result = '0;
        endcase
    end

endmodule

// File: core/idu.sv
`timescale 1ns/100ps
`include "rv_macros.svh"

module idu
(
    input  logic [`XLEN-1:0]       inst,
    output rv_isa_pkg::inst_e      inst_id,
    output rv_isa_pkg::fmt_e       fmt,
    output logic [`XLEN-1:0]       imm,
    output logic [`REG_ADDR_W-1:0] rs1,
    output logic [`REG_ADDR_W-1:0] rs2,
    output logic [`REG_ADDR_W-1:0] rd
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd  = inst[11:7];

    always_comb
    begin
        inst_id = rv_isa_pkg::INST_NONE;
        fmt     = rv_isa_pkg::FMT_NONE;
        if (inst == `XLEN'h0010_0073)
        begin
            inst_id = rv_isa_pkg::INST_EBREAK; // ebreak has no free fields
            fmt     = rv_isa_pkg::FMT_I;
        end
        else if (opcode == 7'b0010111)
        begin
            inst_id = rv_isa_pkg::INST_AUIPC;
            fmt     = rv_isa_pkg::FMT_U;
        end
        else if (opcode == 7'b1101111)
        begin
            inst_id = rv_isa_pkg::INST_JAL;
            fmt     = rv_isa_pkg::FMT_J;
        end
        else if (opcode == 7'b1100111 && funct3 == 3'b000)
        begin
            inst_id = rv_isa_pkg::INST_JALR;
            fmt     = rv_isa_pkg::FMT_I;
        end
        else if (opcode == 7'b1100011 && funct3 == 3'b000)
        begin
            inst_id = rv_isa_pkg::INST_BEQ;
            fmt     = rv_isa_pkg::FMT_B;
        end
        else if (opcode == 7'b0100011 && funct3 == 3'b010)
        begin
            inst_id = rv_isa_pkg::INST_SW;
            fmt     = rv_isa_pkg::FMT_S;
        end
        else if (opcode == 7'b0010011 && funct3 == 3'b000)
        begin
            inst_id = rv_isa_pkg::INST_ADDI;
            fmt     = rv_isa_pkg::FMT_I;
        end
        else if (opcode == 7'b0110011 && funct3 == 3'b000 && funct7 == 7'b0000000)
        begin
            inst_id = rv_isa_pkg::INST_ADD;
            fmt     = rv_isa_pkg::FMT_R;
        end
    end

    always_comb
    begin
        case (fmt)
            rv_isa_pkg::FMT_I: imm = {{(`XLEN-12){inst[31]}}, inst[31:20]};
            rv_isa_pkg::FMT_S: imm = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
            rv_isa_pkg::FMT_B: imm = {{(`XLEN-12){inst[31]}}, inst[7], inst[30:25],
                                      inst[11:8], 1'b0};
            rv_isa_pkg::FMT_U: imm = {inst[31:12], 12'b0};
            rv_isa_pkg::FMT_J: imm = {{(`XLEN-20){inst[31]}}, inst[19:12], inst[20],
                                      inst[30:21], 1'b0};
            default:           imm = '0; // R format and undecoded words carry none
        endcase
    end

    always_comb
    begin
        assert (fmt != rv_isa_pkg::FMT_NONE || inst_id == rv_isa_pkg::INST_NONE)
            else $error("idu: format missing for a decoded instruction");
    end

endmodule

// File: common/rv_alu_pkg.sv
package rv_alu_pkg;

    // beq compares through the xor path
    typedef enum logic [1:0] {
        ALU_NONE,
        ALU_ADD,
        ALU_XOR
    } alu_op_e;

endpackage

// File: common/rv_isa_pkg.sv
package rv_isa_pkg;

    // instructions the core executes, INST_NONE marks an undecoded word
    typedef enum logic [3:0] {
        INST_NONE,
        INST_AUIPC,
        INST_JAL,
        INST_JALR,
        INST_BEQ,
        INST_SW,
        INST_ADDI,
        INST_ADD,
        INST_EBREAK
    } inst_e;

    typedef enum logic [2:0] {
        FMT_NONE,
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J
    } fmt_e;

endpackage

// File: common/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// data path and address width of the core
`define XLEN 32

// register index width, 32 architectural registers
`define REG_ADDR_W 5

// fetch address after reset
`define BASE_ADDR `XLEN'h8000_0000

`endif
